//--- sim.f
+incdir+verif
verilog/core_pkg.sv
verilog/inst_intake.sv
verilog/stage_decode.sv
verilog/stage_execute.sv
verilog/stage_wb.sv
verilog/core_top.sv
verif/core_tb.sv

//--- Bender.yml
package:
  name: rv32i_backend

sources:
  - files:
      - verilog/core_pkg.sv
      - verilog/inst_intake.sv
      - verilog/stage_decode.sv
      - verilog/stage_execute.sv
      - verilog/stage_wb.sv
      - verilog/core_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/core_tb.sv

//--- verif/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// architectural register state as the program sees it.
word_t model_regs [32];

function automatic void model_reset();
    model_regs[0] = 32'h0000_0000;
    for (int i = 1; i < 32; i++) begin
        model_regs[i] = 32'hffff_ffff;
    end
endfunction

// b is rs2 for register ops and the immediate otherwise.
function automatic word_t rv32_alu(input logic [2:0] f3, input logic alt, input word_t a,
                                   input word_t b);
    word_t r;
    case (f3)
        3'b000: r = alt ? a - b : a + b;
        3'b001: r = a << b[4:0];
        3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: r = (a < b) ? 32'd1 : 32'd0;
        3'b100: r = a ^ b;
        3'b101: r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// executes one instruction and returns what should retire.
function automatic retire_t model_execute(input word_t pc, input word_t inst);
    retire_t res;
    logic [2:0] f3;
    logic alt;
    word_t imm;
    f3 = inst[14:12];
    alt = inst[31:25] == 7'b0100000;
    imm = {{20{inst[31]}}, inst[31:20]};
    res.pc = pc;
    res.rd = inst[11:7];
    res.wen = 1'b0;
    res.wdata = '0;
    case (inst[6:0])
        7'b0110011: begin
            res.wen = 1'b1;
            res.wdata = rv32_alu(f3, alt, model_regs[inst[19:15]], model_regs[inst[24:20]]);
        end
        7'b0010011: begin
            res.wen = 1'b1;
            res.wdata = rv32_alu(f3, alt && f3 == 3'b101, model_regs[inst[19:15]], imm);
        end
        7'b0110111: begin
            res.wen = 1'b1;
            res.wdata = {inst[31:12], 12'h000};
        end
        default: begin
            res.wen = 1'b0;
        end
    endcase
    if (res.wen && res.rd != 5'd0) begin
        model_regs[res.rd] = res.wdata;
    end
    return res;
endfunction

`endif

//--- verif/core_tb.sv
`timescale 1ns/1ns

module core_tb;
    import core_pkg::*;

    localparam int clk_period = 10;
    localparam int random_insts = 200;
    localparam int total_insts = 10 + random_insts + 24 + 16;

    logic clk = 1'b0;
    logic reset;
    logic req;
    fetch_word_t fetch;
    logic ack;
    logic retire_valid;
    retire_t retire;
    logic [31:0] inst_count;

    retire_t expected_q [$];
    word_t next_pc = 32'h0000_1000;
    int handshakes = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_checks;
    int test_errors;
    string test_name = "reset";
    logic prev_ack = 1'b0;
    logic prev_req = 1'b0;
    logic [6:0] unsup_opc [4] = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111};

    `include "ref_model.svh"

    core_top dut (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .fetch        (fetch),
        .ack          (ack),
        .retire_valid (retire_valid),
        .retire       (retire),
        .inst_count   (inst_count)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // mostly x0 to x7 so that dependencies show up often.
    function automatic reg_addr_t pick_reg();
        if ($urandom_range(7, 0) != 0) begin
            return reg_addr_t'($urandom_range(7, 0));
        end
        return reg_addr_t'($urandom_range(31, 0));
    endfunction

    function automatic word_t random_inst();
        logic [2:0] f3;
        logic [11:0] imm;
        int kind;
        word_t inst;
        f3 = 3'($urandom_range(7, 0));
        kind = $urandom_range(9, 0);
        imm = 12'($urandom);
        inst = $urandom;
        if (kind < 4) begin
            inst = enc_r(((f3 == 3'b000 || f3 == 3'b101) && imm[0]) ? 7'b0100000 : 7'b0,
                         pick_reg(), pick_reg(), f3, pick_reg());
        end else if (kind < 8) begin
            if (f3 == 3'b001 || f3 == 3'b101) begin
                imm[11:5] = (f3 == 3'b101 && imm[11]) ? 7'b0100000 : 7'b0;
            end
            inst = enc_i(imm, pick_reg(), f3, pick_reg());
        end else if (kind == 8) begin
            inst[11:7] = pick_reg();
            inst[6:0] = 7'b0110111;
        end else begin
            inst[6:0] = unsup_opc[$urandom_range(3, 0)];
        end
        return inst;
    endfunction

    // four-phase handshake, one instruction; the model runs when ack rises.
    task automatic send(input word_t inst, input int max_gap);
        repeat ($urandom_range(max_gap, 0)) begin
            @(posedge clk);
            #1;
        end
        req = 1'b1;
        fetch = '{pc: next_pc, inst: inst};
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        expected_q.push_back(model_execute(next_pc, inst));
        req = 1'b0;
        next_pc += 32'd4;
        do begin
            @(posedge clk);
            #1;
        end while (ack);
        handshakes++;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (2) @(posedge clk);
        #1;
        tests++;
        $display("test %s: %0d checks, %0d errors", test_name, checks - test_checks,
                 errors - test_errors);
    endtask

    always @(negedge clk) begin : retire_check
        retire_t exp;
        if (!reset && retire_valid) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("%s: retirement of pc %h with no instruction outstanding",
                         test_name, retire.pc);
            end else begin
                exp = expected_q.pop_front();
                check_value({test_name, " pc"}, exp.pc, retire.pc);
                check_value({test_name, " rd"}, word_t'(exp.rd), word_t'(retire.rd));
                check_value({test_name, " wen"}, word_t'(exp.wen), word_t'(retire.wen));
                if (exp.wen) begin
                    check_value({test_name, " wdata"}, exp.wdata, retire.wdata);
                end
            end
        end
    end

    // req as sampled by the edge where ack changes.
    always @(negedge clk) begin
        if (!reset && ack && !prev_ack) begin
            check_value({test_name, " ack rise with req"}, 32'd1, word_t'(prev_req));
        end
        if (!reset && !ack && prev_ack) begin
            check_value({test_name, " ack fall after req"}, 32'd0, word_t'(prev_req));
        end
        prev_ack = ack;
        prev_req = req;
    end

    initial begin : watchdog
        #(20 * total_insts * 10 * clk_period);
        $display("timeout: run stalled after %0d handshakes", handshakes);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        word_t inst;
        void'($urandom(32'h1db1));
        reset = 1'b1;
        req = 1'b0;
        fetch = '0;
        model_reset();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test("reset_values");
        check_value("reset_values ack", 32'd0, word_t'(ack));
        check_value("reset_values inst_count", 32'd0, inst_count);
        for (int r = 1; r < 8; r++) begin
            send(enc_i(12'd0, reg_addr_t'(r), 3'b000, reg_addr_t'(r + 16)), 2);
        end
        send(enc_i(12'd0, 5'd0, 3'b000, 5'd24), 2);
        send(enc_i(12'h05a, 5'd1, 3'b000, 5'd0), 2);
        send(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd25), 2);
        end_test();

        begin_test("alu_random");
        for (int i = 0; i < random_insts; i++) begin
            send(random_inst(), 3);
        end
        end_test();

        // each instruction needs the one before it.
        begin_test("dependent_chain");
        for (int i = 0; i < 12; i++) begin
            send(enc_i(12'(i * 3 + 1), 5'd5, 3'b000, 5'd5), 0);
            send(enc_r(7'b0, 5'd5, 5'd6, 3'b100, 5'd6), 0);
        end
        end_test();

        begin_test("unsupported");
        for (int i = 0; i < 8; i++) begin
            inst = $urandom;
            inst[11:7] = reg_addr_t'(i % 7 + 1);
            inst[6:0] = unsup_opc[i % 4];
            send(inst, 1);
        end
        for (int r = 0; r < 8; r++) begin
            send(enc_i(12'd0, reg_addr_t'(r), 3'b000, reg_addr_t'(r + 8)), 1);
        end
        end_test();

        begin_test("final_count");
        check_value("final_count inst_count", word_t'(handshakes), inst_count);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  core_pkg::fetch_word_t fetch,
    output logic                  ack,
    output logic                  retire_valid,
    output core_pkg::retire_t     retire,
    output logic [31:0]           inst_count
);
    import core_pkg::*;

    logic        slot_valid;
    fetch_word_t slot;
    logic        take;
    word_t       regfile [reg_count];
    logic        clear_valid;
    reg_addr_t   clear_addr;
    logic        dec_valid;
    decoded_t    dec;
    logic        ex_valid;
    retire_t     ex;

    inst_intake u_intake (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .fetch      (fetch),
        .ack        (ack),
        .slot_valid (slot_valid),
        .slot       (slot),
        .take       (take)
    );

    stage_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .slot_valid  (slot_valid),
        .slot        (slot),
        .take        (take),
        .regfile     (regfile),
        .clear_valid (clear_valid),
        .clear_addr  (clear_addr),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

    stage_execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .dec_valid (dec_valid),
        .dec       (dec),
        .ex_valid  (ex_valid),
        .ex        (ex)
    );

    stage_wb u_wb (
        .clk          (clk),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex           (ex),
        .regfile      (regfile),
        .clear_valid  (clear_valid),
        .clear_addr   (clear_addr),
        .retire_valid (retire_valid),
        .retire       (retire),
        .inst_count   (inst_count)
    );

endmodule

//--- verilog/stage_wb.sv
`timescale 1ns/1ns

module stage_wb (
    input  logic                clk,
    input  logic                reset,
    input  logic                ex_valid,
    input  core_pkg::retire_t   ex,
    output core_pkg::word_t     regfile [core_pkg::reg_count],
    output logic                clear_valid,
    output core_pkg::reg_addr_t clear_addr,
    output logic                retire_valid,
    output core_pkg::retire_t   retire,
    output logic [31:0]         inst_count
);
    import core_pkg::*;

    logic rf_write;

    // x0 is never written.
    assign rf_write = ex_valid && ex.wen && ex.rd != '0;

    // frees the scoreboard at the same edge as the write.
    assign clear_valid = rf_write;
    assign clear_addr = ex.rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            regfile[0] <= '0;
            for (int i = 1; i < reg_count; i++) begin
                regfile[i] <= reg_reset_value;
            end
        end else if (rf_write) begin
            regfile[ex.rd] <= ex.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_count <= '0;
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
            if (ex_valid) begin
                inst_count <= inst_count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire <= ex;
        end
    end

    // a bad value here would poison later reads.
    wdata_known: assert property (
        @(posedge clk) disable iff (reset)
        rf_write |-> !$isunknown(ex.wdata)
    );

endmodule

//--- verilog/stage_execute.sv
`timescale 1ns/1ns

module stage_execute (
    input  logic               clk,
    input  logic               reset,
    input  logic               dec_valid,
    input  core_pkg::decoded_t dec,
    output logic               ex_valid,
    output core_pkg::retire_t  ex
);
    import core_pkg::*;

    logic [4:0] shamt;
    word_t result;

    assign shamt = dec.b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add: begin
                result = dec.a + dec.b;
            end
            alu_sub: begin
                result = dec.a - dec.b;
            end
            alu_sll: begin
                result = dec.a << shamt;
            end
            alu_slt: begin
                result = {{(xlen - 1){1'b0}}, $signed(dec.a) < $signed(dec.b)};
            end
            alu_sltu: begin
                result = {{(xlen - 1){1'b0}}, dec.a < dec.b};
            end
            alu_xor: begin
                result = dec.a ^ dec.b;
            end
            alu_srl: begin
                result = dec.a >> shamt;
            end
            alu_sra: begin
                result = word_t'($signed(dec.a) >>> shamt);
            end
            alu_or: begin
                result = dec.a | dec.b;
            end
            alu_and: begin
                result = dec.a & dec.b;
            end
            alu_pass_b: begin
                result = dec.b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    // payload follows the valid bit.
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex.pc <= dec.pc;
            ex.rd <= dec.rd;
            ex.wen <= dec.wen;
            ex.wdata <= result;
        end
    end

endmodule

//--- verilog/stage_decode.sv
`timescale 1ns/1ns

module stage_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  slot_valid,
    input  core_pkg::fetch_word_t slot,
    output logic                  take,
    input  core_pkg::word_t       regfile [core_pkg::reg_count],
    input  logic                  clear_valid,
    input  core_pkg::reg_addr_t   clear_addr,
    output logic                  dec_valid,
    output core_pkg::decoded_t    dec
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t imm_i;
    word_t imm_u;
    word_t rs1_data;
    word_t rs2_data;
    word_t operand_b;
    alu_op_e alu_op;
    logic use_rs1;
    logic use_rs2;
    logic wen;
    logic stall;
    logic [reg_count-1:0] pending;

    function automatic alu_op_e select_op(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            f3_add_sub: op = alt ? alu_sub : alu_add;
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = slot.inst[6:0];
    assign rd = slot.inst[11:7];
    assign funct3 = slot.inst[14:12];
    assign rs1 = slot.inst[19:15];
    assign rs2 = slot.inst[24:20];
    assign funct7 = slot.inst[31:25];

    assign imm_i = {{20{slot.inst[31]}}, slot.inst[31:20]};
    assign imm_u = {slot.inst[31:12], 12'b0};

    assign rs1_data = regfile[rs1];
    assign rs2_data = regfile[rs2];

    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        wen = 1'b0;
        alu_op = alu_add;
        operand_b = imm_i;
        case (opcode)
            opc_op: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                wen = 1'b1;
                alu_op = select_op(funct3, funct7 == f7_alt);
                operand_b = rs2_data;
            end
            opc_op_imm: begin
                use_rs1 = 1'b1;
                wen = 1'b1;
                // only the shift right immediates carry funct7.
                alu_op = select_op(funct3, funct3 == f3_srl_sra && funct7 == f7_alt);
            end
            opc_lui: begin
                wen = 1'b1;
                alu_op = alu_pass_b;
                operand_b = imm_u;
            end
            default: begin
                wen = 1'b0;
            end
        endcase
    end

    // rd is checked too, so one writer per register is in flight.
    assign stall = (use_rs1 && pending[rs1]) || (use_rs2 && pending[rs2])
                   || (wen && pending[rd]);
    assign take = slot_valid && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (clear_valid) begin
                pending[clear_addr] <= 1'b0;
            end
            if (take && wen && rd != '0) begin
                pending[rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            dec.pc <= slot.pc;
            dec.alu_op <= alu_op;
            dec.a <= rs1_data;
            dec.b <= operand_b;
            dec.rd <= rd;
            dec.wen <= wen;
        end
    end

    x0_never_pending: assert property (
        @(posedge clk) disable iff (reset)
        !pending[0]
    );

    // every writeback clear matches an issued write.
    clear_was_pending: assert property (
        @(posedge clk) disable iff (reset)
        clear_valid |-> pending[clear_addr]
    );

endmodule

//--- verilog/inst_intake.sv
`timescale 1ns/1ns

module inst_intake (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req,
    input  core_pkg::fetch_word_t fetch,
    output logic                 ack,
    output logic                 slot_valid,
    output core_pkg::fetch_word_t slot,
    input  logic                 take
);
    import core_pkg::*;

    logic accept;

    // new request only while the slot is empty and the last one is closed.
    assign accept = req && !ack && !slot_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ack <= 1'b0;
        end else if (accept) begin
            ack <= 1'b1;
        end else if (!req && ack) begin
            ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (accept) begin
            slot_valid <= 1'b1;
        end else if (take) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            slot <= fetch;
        end
    end

    // ack only rises on a sampled req.
    ack_follows_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req)
    );

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;
    localparam int reg_count = 32;
    localparam int reg_addr_w = $clog2(reg_count);

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // x0 stays zero, the rest come up all ones.
    localparam word_t reg_reset_value = '1;

    // major opcodes.
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // selects sub and sra.
    localparam logic [6:0] f7_alt = 7'b0100000;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_word_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     a;
        word_t     b;
        reg_addr_t rd;
        logic      wen;
    } decoded_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      wen;
        word_t     wdata;
    } retire_t;

endpackage
